// ==== build.f ====
+incdir+.
imuldiv_pkg.sv
int_mul_iterative.sv
int_div_dpath.sv
int_div_ctrl.sv
imuldiv_unit.sv
tb_imuldiv.sv

// ==== Bender.yml ====
package:
  name: imuldiv

sources:
  - files:
      - imuldiv_pkg.sv
      - int_mul_iterative.sv
      - int_div_dpath.sv
      - int_div_ctrl.sv
      - imuldiv_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_imuldiv.sv

// ==== tb_vectors.svh ====
/* directed cases for the multiply/divide testbench, included inside its module
   columns of each add_case call: name, function, a, b, stall cycles */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

function automatic void add_directed_cases();
  // ----------------------------------------------------------
  // unsigned divide
  // ----------------------------------------------------------
  add_case("divu_basic",      fn_divu, 32'd100,        32'd7,          0);
  add_case("divu_a_lt_b",     fn_divu, 32'd7,          32'd100,        1);
  add_case("divu_by_one",     fn_divu, 32'hdeadbeef,   32'd1,          0);
  add_case("divu_max_by_max", fn_divu, 32'hffffffff,   32'hffffffff,   0);
  add_case("divu_max_by_2",   fn_divu, 32'hffffffff,   32'd2,          3);
  // top bit set, must not be read as negative
  add_case("divu_msb_by_3",   fn_divu, 32'h80000000,   32'd3,          0);
  add_case("divu_by_pow2",    fn_divu, 32'd12345678,   32'h00010000,   0);

  // ----------------------------------------------------------
  // signed divide, all four sign pairs
  // ----------------------------------------------------------
  add_case("div_pos_pos",     fn_div,  32'd100,        32'd7,          0);
  add_case("div_neg_pos",     fn_div,  -32'sd100,      32'd7,          2);
  add_case("div_pos_neg",     fn_div,  32'd100,        -32'sd7,        0);
  add_case("div_neg_neg",     fn_div,  -32'sd100,      -32'sd7,        0);
  // overflow case, quotient wraps back to most negative
  add_case("div_min_by_m1",   fn_div,  32'h80000000,   -32'sd1,        0);
  add_case("div_min_by_1",    fn_div,  32'h80000000,   32'd1,          1);
  add_case("div_m1_by_2",     fn_div,  -32'sd1,        32'd2,          0);
  add_case("div_a_lt_b",      fn_div,  32'd7,          -32'sd100,      0);

  // ----------------------------------------------------------
  // signed multiply
  // ----------------------------------------------------------
  add_case("mul_basic",       fn_mul,  32'd3,          32'd5,          0);
  add_case("mul_neg_pos",     fn_mul,  -32'sd3,        32'd5,          0);
  add_case("mul_neg_neg",     fn_mul,  -32'sd3,        -32'sd5,        5);
  add_case("mul_min_by_min",  fn_mul,  32'h80000000,   32'h80000000,   0);
  add_case("mul_min_by_m1",   fn_mul,  32'h80000000,   -32'sd1,        0);
  add_case("mul_max_by_max",  fn_mul,  32'h7fffffff,   32'h7fffffff,   1);
  add_case("mul_m1_by_1",     fn_mul,  32'hffffffff,   32'd1,          0);
  add_case("mul_by_zero",     fn_mul,  32'd0,          32'h12345678,   0);
endfunction

`endif

// ==== tb_imuldiv.sv ====
/* testbench for the multiply/divide unit, runs a directed table and random cases
   through the val/rdy ports and checks results, latency and back-pressure */
`timescale 1ns/10ps

module tb_imuldiv import imuldiv_pkg::*; ();

  // cycles any single wait may take before giving up
  localparam int wait_limit = 200;

  // one table entry
  typedef struct {
    string           name;
    muldiv_fn_t      fn;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    int              stall;  // cycles resp_rdy stays low with a response waiting
  } test_case_t;

  logic           clk = 1'b0;
  logic           reset;
  muldiv_req_t    req;
  logic           req_val;
  logic           req_rdy;
  muldiv_result_u resp;
  logic           resp_val;
  logic           resp_rdy;

  test_case_t cases[$];
  int         tests;
  int         errors;

  // 4 ns period
  always #2 clk = ~clk;

  imuldiv_unit u_imuldiv_unit (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // ----------------------------------------------------------
  // table building and reference model
  // ----------------------------------------------------------

  function automatic void add_case(string name, muldiv_fn_t fn, logic [xlen-1:0] a,
                                   logic [xlen-1:0] b, int stall);
    test_case_t tc;
    tc.name  = name;
    tc.fn    = fn;
    tc.a     = a;
    tc.b     = b;
    tc.stall = stall;
    cases.push_back(tc);
  endfunction

  `include "tb_vectors.svh"

  // random operands with a nonzero divisor for divides
  function automatic void add_random_cases(int n);
    muldiv_fn_t      fn;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    for (int i = 0; i < n; i++) begin
      fn = muldiv_fn_t'($urandom_range(2, 0));
      a  = $urandom;
      b  = $urandom;
      if (b == '0 && fn != fn_mul) begin
        b = 32'd1;
      end
      add_case($sformatf("rand_%0d", i), fn, a, b, $urandom_range(3, 0));
    end
  endfunction

  // 64-bit math so most negative by -1 wraps to 0x80000000 in the low word
  function automatic logic [2*xlen-1:0] model_result(muldiv_fn_t fn, logic [xlen-1:0] a,
                                                     logic [xlen-1:0] b);
    longint          sa;
    longint          sb;
    logic [xlen-1:0] q;
    logic [xlen-1:0] r;
    sa = $signed(a);
    sb = $signed(b);
    case (fn)
      fn_mul: begin
        return sa * sb;
      end
      fn_div: begin
        q = sa / sb;
        r = sa % sb;
      end
      default: begin
        q = a / b;
        r = a % b;
      end
    endcase
    return {r, q};
  endfunction

  // ----------------------------------------------------------
  // one request/response exchange
  // ----------------------------------------------------------

  task automatic apply_case(input test_case_t tc, output bit expired);
    logic [2*xlen-1:0] exp_val;
    logic [2*xlen-1:0] got;
    logic [2*xlen-1:0] held;
    int                waited;
    int                latency;
    bit                case_ok;
    expired = 1'b0;
    case_ok = 1'b1;
    exp_val = model_result(tc.fn, tc.a, tc.b);
    req.fn   <= tc.fn;
    req.a    <= tc.a;
    req.b    <= tc.b;
    req_val  <= 1'b1;
    resp_rdy <= (tc.stall == 0);
    // edge that sees req_rdy high is the accepting edge
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!req_rdy && waited < wait_limit);
    if (!req_rdy) begin
      $display("timeout: req_rdy never came back before test %s", tc.name);
      expired = 1'b1;
      return;
    end
    req_val <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!resp_val && waited < wait_limit);
    if (!resp_val) begin
      $display("timeout: no resp_val for test %s", tc.name);
      expired = 1'b1;
      return;
    end
    // resp_val rose one edge before the edge that sees it
    latency = waited - 1;
    held    = resp.product;
    if (tc.fn == fn_mul) begin
      got = resp.product;
    end else begin
      got = resp.divrem;
    end
    assert (latency == step_count) else begin
      $display("Fail %s latency: expected %0d, actual %0d", tc.name, step_count, latency);
      case_ok = 1'b0;
    end
    assert (got === exp_val) else begin
      $display("Fail %s: expected %h, actual %h", tc.name, exp_val, got);
      case_ok = 1'b0;
    end
    // response must sit still and req_rdy stay low under back-pressure
    // resp_rdy rises in time for the last stalled edge to take the response
    for (int s = 0; s < tc.stall; s++) begin
      if (s == tc.stall - 1) begin
        resp_rdy <= 1'b1;
      end
      @(posedge clk);
      assert (resp_val === 1'b1 && req_rdy === 1'b0 && resp.product === held) else begin
        $display("Fail %s back-pressure: expected resp_val=1 req_rdy=0 resp=%h,",
                 tc.name, held);
        $display("     actual resp_val=%b req_rdy=%b resp=%h",
                 resp_val, req_rdy, resp.product);
        case_ok = 1'b0;
      end
    end
    tests++;
    if (!case_ok) begin
      errors++;
    end
    $display("%-4s %-16s fn=%0d a=%h b=%h result=%h latency=%0d stall=%0d",
             case_ok ? "ok" : "bad", tc.name, tc.fn, tc.a, tc.b, got, latency, tc.stall);
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------

  initial begin : run
    bit expired;
    expired  = 1'b0;
    tests    = 0;
    errors   = 0;
    reset    = 1'b1;
    req      = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    void'($urandom(3));
    add_directed_cases();
    add_random_cases(40);

    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    // idle port straight out of reset
    tests++;
    assert (req_rdy === 1'b1 && resp_val === 1'b0) else begin
      $display("Fail reset_state: expected req_rdy=1 resp_val=0, actual req_rdy=%b resp_val=%b",
               req_rdy, resp_val);
      errors++;
    end
    $display("done reset_state req_rdy=%b resp_val=%b", req_rdy, resp_val);

    foreach (cases[i]) begin
      apply_case(cases[i], expired);
      if (expired) begin
        errors++;
        break;
      end
    end

    $display("tests run %0d, failed %0d", tests, errors);
    if (errors == 0 && !expired) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== imuldiv_unit.sv ====
/* top of the multiply/divide unit, one val/rdy request port and one response port
   steers each request to the multiplier or divider and merges their responses */
`timescale 1ns/10ps

module imuldiv_unit import imuldiv_pkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  muldiv_req_t    req,
  input  logic           req_val,
  output logic           req_rdy,
  output muldiv_result_u resp,
  output logic           resp_val,
  input  logic           resp_rdy
);

  // multiplier side
  logic              mul_req_val;
  logic              mul_req_rdy;
  logic [2*xlen-1:0] mul_product;
  logic              mul_resp_val;
  muldiv_result_u    mul_result;

  // divider side
  logic              div_req_val;
  logic              div_req_rdy;
  logic              div_resp_val;
  div_ctrl_t         div_ctrl;
  div_status_t       div_status;
  muldiv_result_u    div_result;

  logic is_mul;
  logic is_div;

  // ----------------------------------------------------------
  // request routing
  // ----------------------------------------------------------

  assign is_mul = (req.fn == fn_mul);
  assign is_div = (req.fn == fn_div) || (req.fn == fn_divu);

  // accept only with both blocks idle, one request in flight
  assign req_rdy = mul_req_rdy && div_req_rdy;

  // gated with req_rdy so neither block starts while the other is busy
  assign mul_req_val = req_val && req_rdy && is_mul;
  assign div_req_val = req_val && req_rdy && is_div;

  int_mul_iterative u_mul (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .product  (mul_product),
    .resp_val (mul_resp_val),
    .resp_rdy (resp_rdy)
  );

  int_div_ctrl u_div_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp_val (div_resp_val),
    .resp_rdy (resp_rdy),
    .ctrl     (div_ctrl),
    .status   (div_status)
  );

  int_div_dpath u_div_dpath (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .ctrl   (div_ctrl),
    .status (div_status),
    .result (div_result)
  );

  // ----------------------------------------------------------
  // response merge
  // ----------------------------------------------------------

  assign mul_result.product = mul_product;

  // at most one block holds a response at a time
  assign resp_val = mul_resp_val || div_resp_val;
  assign resp     = mul_resp_val ? mul_result : div_result;

endmodule

// ==== int_div_ctrl.sv ====
/* control FSM for the iterative divider
   sequences load, 32 restoring steps and the response handshake */
`timescale 1ns/10ps

module int_div_ctrl import imuldiv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        req_val,
  output logic        req_rdy,
  output logic        resp_val,
  input  logic        resp_rdy,
  output div_ctrl_t   ctrl,
  input  div_status_t status
);

  fsm_state_t       state;
  logic [cnt_w-1:0] count;

  logic req_go;
  logic resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // status.sub_neg is not needed here
  // the dpath picks the quotient bit itself, one step per edge

  // ----------------------------------------------------------
  // state and step counter
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      unique case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        // last step lands on the edge that enters done
        st_calc: begin
          if (count == last_step) begin
            state <= st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_done: begin
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ----------------------------------------------------------
  // outputs from state
  // ----------------------------------------------------------

  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    ctrl     = '0;
    unique case (state)
      // rdy is high here, so a valid request is a transfer
      st_idle: begin
        req_rdy      = 1'b1;
        ctrl.a_en    = req_val;
        ctrl.b_en    = req_val;
        ctrl.sign_en = req_val;
      end
      // iterate, divisor and signs stay put
      st_calc: begin
        ctrl.a_en      = 1'b1;
        ctrl.a_mux_sel = 1'b1;
      end
      st_done: begin
        resp_val = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== int_div_dpath.sv ====
/* restoring divider datapath, driven by int_div_ctrl enables
   divides magnitudes, then corrects quotient and remainder signs */
`timescale 1ns/10ps

module int_div_dpath import imuldiv_pkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  muldiv_req_t    req,
  input  div_ctrl_t      ctrl,
  output div_status_t    status,
  output muldiv_result_u result
);

  // sign info captured with the operands
  logic is_signed;
  logic a_neg;
  logic b_neg;

  // remainder in the upper part, quotient bits shift in at the bottom
  logic [div_w-1:0] rq_reg;
  // divisor aligned to the remainder half
  logic [div_w-1:0] dvsr_reg;

  logic [xlen-1:0]  a_mag;
  logic [xlen-1:0]  b_mag;
  logic [div_w-1:0] rq_init;
  logic [div_w-1:0] rq_shift;
  logic [div_w-1:0] diff;
  logic [div_w-1:0] rq_step;
  logic             sub_neg;
  logic [xlen-1:0]  quot_mag;
  logic [xlen-1:0]  rem_mag;
  logic             quot_neg;
  logic             rem_neg;

  // ----------------------------------------------------------
  // operand magnitudes
  // ----------------------------------------------------------

  // only signed divide takes absolute values, divu uses raw words
  assign a_mag = neg_word((req.fn == fn_div) && req.a[xlen-1], req.a);
  assign b_mag = neg_word((req.fn == fn_div) && req.b[xlen-1], req.b);

  assign rq_init = {{(xlen+1){1'b0}}, a_mag};

  // ----------------------------------------------------------
  // one restoring step
  // ----------------------------------------------------------

  assign rq_shift = rq_reg << 1;
  assign diff     = rq_shift - dvsr_reg;
  // top bit set means the divisor did not fit
  assign sub_neg  = diff[div_w-1];

  // keep difference with quotient bit 1, or restore with bit 0
  assign rq_step = sub_neg ? {rq_shift[div_w-1:1], 1'b0} : {diff[div_w-1:1], 1'b1};

  assign status.sub_neg = sub_neg;

  // sign flags
  always_ff @(posedge clk) begin
    if (reset) begin
      is_signed <= 1'b0;
      a_neg     <= 1'b0;
      b_neg     <= 1'b0;
    end else if (ctrl.sign_en) begin
      is_signed <= (req.fn == fn_div);
      a_neg     <= req.a[xlen-1];
      b_neg     <= req.b[xlen-1];
    end
  end

  // working registers
  always_ff @(posedge clk) begin
    if (ctrl.a_en) begin
      rq_reg <= ctrl.a_mux_sel ? rq_step : rq_init;
    end
    if (ctrl.b_en) begin
      dvsr_reg <= {1'b0, b_mag, {xlen{1'b0}}};
    end
  end

  // ----------------------------------------------------------
  // sign correction
  // ----------------------------------------------------------

  // after 32 steps the remainder sits just above the quotient
  assign quot_mag = rq_reg[xlen-1:0];
  assign rem_mag  = rq_reg[2*xlen-1:xlen];

  // quotient truncates toward zero, remainder follows the dividend
  assign quot_neg = is_signed && (a_neg ^ b_neg);
  assign rem_neg  = is_signed && a_neg;

  always_comb begin
    result.divrem.rem  = neg_word(rem_neg, rem_mag);
    result.divrem.quot = neg_word(quot_neg, quot_mag);
  end

endmodule

// ==== int_mul_iterative.sv ====
/* iterative signed multiplier, one multiplier bit per cycle
   works on magnitudes and fixes the sign on the way out */
`timescale 1ns/10ps

module int_mul_iterative import imuldiv_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  muldiv_req_t       req,
  input  logic              req_val,
  output logic              req_rdy,
  output logic [2*xlen-1:0] product,
  output logic              resp_val,
  input  logic              resp_rdy
);

  // control state
  fsm_state_t       state;
  logic [cnt_w-1:0] count;

  // payload registers
  logic [2*xlen-1:0] acc;     // running sum of partial products
  logic [2*xlen-1:0] mcand;   // multiplicand, shifted up each step
  logic [xlen-1:0]   mplier;  // multiplier, shifted down each step
  logic              neg;     // operand signs differ

  logic req_go;
  logic resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // ----------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      unique case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        // 32 edges here, then the product is ready
        st_calc: begin
          if (count == last_step) begin
            state <= st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        // hold until the consumer takes it
        st_done: begin
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ----------------------------------------------------------
  // shift-add datapath
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      acc    <= '0;
      // magnitudes; most negative maps to 2^31, still fits unsigned
      mcand  <= {{xlen{1'b0}}, neg_word(req.a[xlen-1], req.a)};
      mplier <= neg_word(req.b[xlen-1], req.b);
      neg    <= req.a[xlen-1] ^ req.b[xlen-1];
    end else if (state == st_calc) begin
      // add shifted multiplicand for each set multiplier bit
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // sign fix is combinational, no extra cycle
  assign product = neg ? (~acc + 1'b1) : acc;

  // handshake from state only
  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);

endmodule

// ==== imuldiv_pkg.sv ====
/* shared widths, function codes and message types for the multiply/divide unit
   import with imuldiv_pkg::* in any module or testbench that needs them */
package imuldiv_pkg;

  // ----------------------------------------------------------
  // widths and step count
  // ----------------------------------------------------------

  // operand width, one word
  localparam int xlen = 32;
  // one result bit per cycle
  localparam int step_count = 32;
  // step counter width and its terminal value
  localparam int cnt_w = $clog2(step_count);
  localparam logic [cnt_w-1:0] last_step = cnt_w'(step_count - 1);
  // divider remainder/quotient register, one guard bit on top
  localparam int div_w = 2 * xlen + 1;

  // ----------------------------------------------------------
  // request and response messages
  // ----------------------------------------------------------

  typedef enum logic [1:0] {
    fn_mul  = 2'd0,  // signed multiply, full product
    fn_div  = 2'd1,  // signed divide
    fn_divu = 2'd2   // unsigned divide
  } muldiv_fn_t;

  typedef struct packed {
    muldiv_fn_t      fn;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
  } muldiv_req_t;

  // divide result, remainder in the upper word
  typedef struct packed {
    logic [xlen-1:0] rem;
    logic [xlen-1:0] quot;
  } divrem_t;

  // one result word, read as product or as remainder/quotient
  typedef union packed {
    logic [2*xlen-1:0] product;
    divrem_t           divrem;
  } muldiv_result_u;

  // ----------------------------------------------------------
  // divider internals and shared FSM encoding
  // ----------------------------------------------------------

  // control from int_div_ctrl to int_div_dpath
  typedef struct packed {
    logic a_en;       // remainder/quotient register write
    logic b_en;       // divisor register write
    logic a_mux_sel;  // 0 load operand, 1 iterate
    logic sign_en;    // capture operand signs and signed-ness
  } div_ctrl_t;

  // status back from the datapath
  typedef struct packed {
    logic sub_neg;    // trial subtraction went negative
  } div_status_t;

  // idle, working, holding response; same for mul and div
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } fsm_state_t;

  // two's complement negate when en is set
  function automatic logic [xlen-1:0] neg_word(input logic en, input logic [xlen-1:0] x);
    return en ? (~x + 1'b1) : x;
  endfunction

endpackage
